//--- verilog/bcd_pkg.sv
package bcd_pkg;

	////////////////////////////////////////
	// Widths with a meaning
	////////////////////////////////////////

	// One decimal digit, 0 to 9 legal
	typedef logic [3:0] bcd_digit_t;

	// Tens in the upper nibble, units in the lower
	typedef logic [7:0] bcd_pair_t;

	// Hundreds, tens, units
	typedef logic [11:0] bcd_sum_t;

	// Segments g down to a, a lit segment is a one
	typedef logic [6:0] segs_t;

	////////////////////////////////////////
	// Buttons
	////////////////////////////////////////

	localparam int N_BTN = 5;

	typedef logic [N_BTN-1:0] btn_vec_t;

	// Bit positions in a button vector
	localparam int BTN_INIT    = 0;
	localparam int BTN_LOAD_A  = 1;
	localparam int BTN_LOAD_B  = 2;
	localparam int BTN_DISP_LS = 3;
	localparam int BTN_DISP_MS = 4;

	// All segments dark
	localparam segs_t SEG_BLANK = 7'b000_0000;

	// Controller states, same sequence as the board controller
	typedef enum logic [2:0] {
		INIT_STATE,
		LOAD_A_STATE,
		DISPLAY_A_STATE,
		LOAD_B_STATE,
		DISPLAY_B_STATE,
		DISPLAY_LS_STATE,
		DISPLAY_MS_STATE
	} ctrl_state_t;

endpackage

//--- verilog/button_sync.sv
module button_sync import bcd_pkg::*; (
	input  logic     CLK,
	input  logic     rst,
	input  btn_vec_t btn_raw,
	output btn_vec_t btn_pulse
);

	// Two flops against metastability
	btn_vec_t sync_1;
	btn_vec_t sync_2;

	// Level seen one cycle earlier, for edge detection
	btn_vec_t prev;

	always_ff @(posedge CLK) begin
		if (rst) begin
			sync_1    <= '0;
			sync_2    <= '0;
			prev      <= '0;
			btn_pulse <= '0;
		end else begin
			sync_1 <= btn_raw;
			sync_2 <= sync_1;
			prev   <= sync_2;
			// Rising edge only, so a held button fires once
			btn_pulse <= sync_2 & ~prev;
		end
	end

endmodule

//--- verilog/bcd_add_controller.sv
module bcd_add_controller import bcd_pkg::*; (
	input  logic     CLK,
	input  logic     rst,
	input  btn_vec_t btn_pulse,
	// Acknowledges back from the operand store
	input  logic     load_a_ack,
	input  logic     load_b_ack,
	// Requests and display mode to the datapath
	output logic     load_a,
	output logic     load_b,
	output logic     display_a,
	output logic     display_b,
	output logic     display_ls,
	output logic     display_ms
);

	ctrl_state_t state;
	ctrl_state_t next_state;

	////////////////////////////////////////
	// Next state
	////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			// Init always falls through to loading A
			INIT_STATE: begin
				next_state = LOAD_A_STATE;
			end

			// Loads wait for their acknowledge, other buttons ignored
			LOAD_A_STATE: begin
				if (load_a_ack)
					next_state = DISPLAY_A_STATE;
			end

			LOAD_B_STATE: begin
				if (load_b_ack)
					next_state = DISPLAY_B_STATE;
			end

			// Display states
			// later button in the list wins
			default: begin
				if (btn_pulse[BTN_LOAD_A])
					next_state = LOAD_A_STATE;
				if (btn_pulse[BTN_LOAD_B])
					next_state = LOAD_B_STATE;
				if (btn_pulse[BTN_DISP_LS])
					next_state = DISPLAY_LS_STATE;
				if (btn_pulse[BTN_DISP_MS])
					next_state = DISPLAY_MS_STATE;
			end
		endcase

		// Init beats everything, in any state
		if (btn_pulse[BTN_INIT])
			next_state = INIT_STATE;
	end

	////////////////////////////////////////
	// State and registered outputs
	////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			state      <= INIT_STATE;
			load_a     <= 1'b0;
			load_b     <= 1'b0;
			display_a  <= 1'b0;
			display_b  <= 1'b0;
			display_ls <= 1'b0;
			display_ms <= 1'b0;
		end else begin
			state <= next_state;

			// Request rises a cycle after entry, drops with the ack
			load_a <= (state == LOAD_A_STATE) && (next_state == LOAD_A_STATE);
			load_b <= (state == LOAD_B_STATE) && (next_state == LOAD_B_STATE);

			// One-hot mode follows the state being entered
			display_a  <= (next_state == DISPLAY_A_STATE);
			display_b  <= (next_state == DISPLAY_B_STATE);
			display_ls <= (next_state == DISPLAY_LS_STATE);
			display_ms <= (next_state == DISPLAY_MS_STATE);
		end
	end

endmodule

//--- verilog/operand_store.sv
module operand_store import bcd_pkg::*; (
	input  logic      CLK,
	input  logic      rst,
	input  bcd_pair_t sw,
	input  logic      load_a,
	input  logic      load_b,
	output logic      load_a_ack,
	output logic      load_b_ack,
	output bcd_pair_t a_val,
	output bcd_pair_t b_val,
	output logic      bcd_err
);

	logic sw_valid;
	logic take_a;
	logic take_b;
	logic pend;

	// Both nibbles must be decimal
	assign sw_valid = (sw[7:4] <= 4'd9) && (sw[3:0] <= 4'd9);

	// Capture once per request; the ack blocks a second take
	assign take_a = load_a && !load_a_ack && sw_valid;
	assign take_b = load_b && !load_b_ack && sw_valid;

	// Request still waiting for its ack
	assign pend = (load_a && !load_a_ack) || (load_b && !load_b_ack);

	always_ff @(posedge CLK) begin
		if (rst) begin
			a_val      <= '0;
			b_val      <= '0;
			load_a_ack <= 1'b0;
			load_b_ack <= 1'b0;
			bcd_err    <= 1'b0;
		end else begin
			if (take_a)
				a_val <= sw;
			if (take_b)
				b_val <= sw;
			// One-cycle acks
			load_a_ack <= take_a;
			load_b_ack <= take_b;
			// Lamp stays lit while a load is refused
			bcd_err <= pend && !sw_valid;
		end
	end

endmodule

//--- verilog/bcd_adder.sv
module bcd_adder import bcd_pkg::*; (
	input  logic      CLK,
	input  logic      rst,
	input  bcd_pair_t a_val,
	input  bcd_pair_t b_val,
	output bcd_sum_t  sum_val
);

	logic [4:0] units_raw;
	logic [4:0] tens_raw;
	logic       units_carry;
	logic       tens_carry;
	bcd_digit_t units_dig;
	bcd_digit_t tens_dig;

	////////////////////////////////////////
	// Units digit
	////////////////////////////////////////

	assign units_raw   = {1'b0, a_val[3:0]} + {1'b0, b_val[3:0]};
	assign units_carry = (units_raw > 5'd9);
	// Add six to skip the six unused codes
	assign units_dig   = units_carry ? bcd_digit_t'(units_raw + 5'd6) : units_raw[3:0];

	////////////////////////////////////////
	// Tens digit, with the units carry
	////////////////////////////////////////

	assign tens_raw   = {1'b0, a_val[7:4]} + {1'b0, b_val[7:4]} + {4'd0, units_carry};
	assign tens_carry = (tens_raw > 5'd9);
	assign tens_dig   = tens_carry ? bcd_digit_t'(tens_raw + 5'd6) : tens_raw[3:0];

	// Hundreds is just the last carry
	always_ff @(posedge CLK) begin
		if (rst)
			sum_val <= '0;
		else
			sum_val <= {3'b000, tens_carry, tens_dig, units_dig};
	end

endmodule

//--- verilog/display_mux.sv
module display_mux import bcd_pkg::*; (
	input  logic      CLK,
	input  logic      rst,
	input  bcd_pair_t a_val,
	input  bcd_pair_t b_val,
	input  bcd_sum_t  sum_val,
	input  logic      display_a,
	input  logic      display_b,
	input  logic      display_ls,
	input  logic      display_ms,
	output segs_t     seg_hi,
	output segs_t     seg_lo
);

	segs_t next_hi;
	segs_t next_lo;

	// Digit to segments, g down to a
	function automatic segs_t seg_encode(input bcd_digit_t dig);
		case (dig)
			4'd0:    seg_encode = 7'b011_1111;
			4'd1:    seg_encode = 7'b000_0110;
			4'd2:    seg_encode = 7'b101_1011;
			4'd3:    seg_encode = 7'b100_1111;
			4'd4:    seg_encode = 7'b110_0110;
			4'd5:    seg_encode = 7'b110_1101;
			4'd6:    seg_encode = 7'b111_1101;
			4'd7:    seg_encode = 7'b000_0111;
			4'd8:    seg_encode = 7'b111_1111;
			4'd9:    seg_encode = 7'b110_1111;
			// Non-decimal codes stay dark
			default: seg_encode = SEG_BLANK;
		endcase
	endfunction

	////////////////////////////////////////
	// Digit selection
	////////////////////////////////////////

	always_comb begin
		next_hi = SEG_BLANK;
		next_lo = SEG_BLANK;
		if (display_a) begin
			next_hi = seg_encode(a_val[7:4]);
			next_lo = seg_encode(a_val[3:0]);
		end else if (display_b) begin
			next_hi = seg_encode(b_val[7:4]);
			next_lo = seg_encode(b_val[3:0]);
		end else if (display_ls) begin
			next_hi = seg_encode(sum_val[7:4]);
			next_lo = seg_encode(sum_val[3:0]);
		end else if (display_ms) begin
			// Hundreds goes on the right digit, left stays dark
			next_lo = seg_encode(sum_val[11:8]);
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			seg_hi <= SEG_BLANK;
			seg_lo <= SEG_BLANK;
		end else begin
			seg_hi <= next_hi;
			seg_lo <= next_lo;
		end
	end

endmodule

//--- verilog/bcd_add_top.sv
module bcd_add_top import bcd_pkg::*; (
	input  logic      CLK,
	input  logic      rst,
	input  bcd_pair_t sw,
	input  btn_vec_t  btn_raw,
	output segs_t     seg_hi,
	output segs_t     seg_lo,
	output logic      led_a,
	output logic      led_b,
	output logic      led_ls,
	output logic      led_ms,
	output logic      bcd_err
);

	btn_vec_t  btn_pulse;

	// Load handshake
	logic      load_a;
	logic      load_b;
	logic      load_a_ack;
	logic      load_b_ack;

	// Datapath values
	bcd_pair_t a_val;
	bcd_pair_t b_val;
	bcd_sum_t  sum_val;

	////////////////////////////////////////
	// Control side
	////////////////////////////////////////

	button_sync button_sync_inst (
		.CLK       (CLK),
		.rst       (rst),
		.btn_raw   (btn_raw),
		.btn_pulse (btn_pulse)
	);

	// Mode outputs double as the lamps
	bcd_add_controller bcd_add_controller_inst (
		.CLK        (CLK),
		.rst        (rst),
		.btn_pulse  (btn_pulse),
		.load_a_ack (load_a_ack),
		.load_b_ack (load_b_ack),
		.load_a     (load_a),
		.load_b     (load_b),
		.display_a  (led_a),
		.display_b  (led_b),
		.display_ls (led_ls),
		.display_ms (led_ms)
	);

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////

	operand_store operand_store_inst (
		.CLK        (CLK),
		.rst        (rst),
		.sw         (sw),
		.load_a     (load_a),
		.load_b     (load_b),
		.load_a_ack (load_a_ack),
		.load_b_ack (load_b_ack),
		.a_val      (a_val),
		.b_val      (b_val),
		.bcd_err    (bcd_err)
	);

	bcd_adder bcd_adder_inst (
		.CLK     (CLK),
		.rst     (rst),
		.a_val   (a_val),
		.b_val   (b_val),
		.sum_val (sum_val)
	);

	display_mux display_mux_inst (
		.CLK        (CLK),
		.rst        (rst),
		.a_val      (a_val),
		.b_val      (b_val),
		.sum_val    (sum_val),
		.display_a  (led_a),
		.display_b  (led_b),
		.display_ls (led_ls),
		.display_ms (led_ms),
		.seg_hi     (seg_hi),
		.seg_lo     (seg_lo)
	);

endmodule

//--- bench/bcd_add_props.sv
module bcd_add_props import bcd_pkg::*; (
	input logic  CLK,
	input logic  rst,
	input segs_t seg_hi,
	input logic  led_a,
	input logic  led_b,
	input logic  led_ls,
	input logic  led_ms,
	input logic  bcd_err
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [3:0] lamps;

	assign lamps = {led_a, led_b, led_ls, led_ms};

	// At most one display mode
	lamps_onehot: assert property (@(posedge CLK) disable iff (rst) $onehot0(lamps))
		else $error("more than one lamp lit");

	// Error lamp only in a load state
	err_no_lamp: assert property (@(posedge CLK) disable iff (rst) !(bcd_err && (|lamps)))
		else $error("bcd_err high with a lamp on");

	// Segments are registered, so blank follows one cycle later
	ms_blank_hi: assert property (@(posedge CLK) disable iff (rst) led_ms |=> seg_hi == SEG_BLANK)
		else $error("seg_hi lit in hundreds mode");

endmodule

bind bcd_add_top bcd_add_props bcd_add_props_inst (
	.CLK     (CLK),
	.rst     (rst),
	.seg_hi  (seg_hi),
	.led_a   (led_a),
	.led_b   (led_b),
	.led_ls  (led_ls),
	.led_ms  (led_ms),
	.bcd_err (bcd_err)
);

//--- bench/bcd_add_tb.sv
module bcd_add_tb import bcd_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	// Roughly 70 cycles per random pair plus the directed tests, with margin
	localparam int MAX_CYCLES = 4000;
	localparam int N_RANDOM   = 40;
	// Longest wait for a load once the request can go through
	localparam int LOAD_WAIT  = 12;

	logic      CLK;
	logic      rst;
	bcd_pair_t sw;
	btn_vec_t  btn_raw;
	segs_t     seg_hi;
	segs_t     seg_lo;
	logic      led_a;
	logic      led_b;
	logic      led_ls;
	logic      led_ms;
	logic      bcd_err;

	// Operands the DUT should be holding
	bcd_pair_t cur_a;
	bcd_pair_t cur_b;

	int cycles = 0;

	bcd_add_top bcd_add_top_inst (
		.CLK     (CLK),
		.rst     (rst),
		.sw      (sw),
		.btn_raw (btn_raw),
		.seg_hi  (seg_hi),
		.seg_lo  (seg_lo),
		.led_a   (led_a),
		.led_b   (led_b),
		.led_ls  (led_ls),
		.led_ms  (led_ms),
		.bcd_err (bcd_err)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Hang guard
	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", cycles);
			$display("Simulation failed");
			$fatal(1, "cycle limit reached");
		end
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Segments g down to a
	function automatic segs_t digit_segs(input bcd_digit_t d);
		case (d)
			4'd0:    return 7'b011_1111;
			4'd1:    return 7'b000_0110;
			4'd2:    return 7'b101_1011;
			4'd3:    return 7'b100_1111;
			4'd4:    return 7'b110_0110;
			4'd5:    return 7'b110_1101;
			4'd6:    return 7'b111_1101;
			4'd7:    return 7'b000_0111;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b110_1111;
			default: return SEG_BLANK;
		endcase
	endfunction

	function automatic int to_decimal(input bcd_pair_t v);
		return int'(v[7:4]) * 10 + int'(v[3:0]);
	endfunction

	// Two legal digits
	function automatic bcd_pair_t random_operand();
		bcd_digit_t tens;
		bcd_digit_t units;
		tens  = bcd_digit_t'($urandom % 10);
		units = bcd_digit_t'($urandom % 10);
		return {tens, units};
	endfunction

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic check_segs(input string name, input segs_t exp, input segs_t act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
			$display("Simulation failed");
			$fatal(1, "segment pattern mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
			$display("Simulation failed");
			$fatal(1, "lamp mismatch");
		end
	endtask

	task automatic check_lamps(input logic a, input logic b, input logic ls, input logic ms);
		check_bit("led_a", a, led_a);
		check_bit("led_b", b, led_b);
		check_bit("led_ls", ls, led_ls);
		check_bit("led_ms", ms, led_ms);
	endtask

	task automatic expect_pair(input bcd_pair_t v);
		check_segs("seg_hi", digit_segs(v[7:4]), seg_hi);
		check_segs("seg_lo", digit_segs(v[3:0]), seg_lo);
	endtask

	// Sum tens and units from the decimal reference
	task automatic expect_sum_low();
		int total;
		total = to_decimal(cur_a) + to_decimal(cur_b);
		check_segs("seg_hi", digit_segs(bcd_digit_t'((total / 10) % 10)), seg_hi);
		check_segs("seg_lo", digit_segs(bcd_digit_t'(total % 10)), seg_lo);
	endtask

	// Left dark, hundreds on the right
	task automatic expect_hundreds();
		int total;
		total = to_decimal(cur_a) + to_decimal(cur_b);
		check_segs("seg_hi", SEG_BLANK, seg_hi);
		check_segs("seg_lo", digit_segs(bcd_digit_t'(total / 100)), seg_lo);
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	task automatic set_switches(input bcd_pair_t v);
		@(posedge CLK);
		sw <= v;
	endtask

	// Held 4 cycles, then 12 to settle, sampled mid-cycle
	task automatic press_buttons(input btn_vec_t mask);
		@(posedge CLK);
		btn_raw <= mask;
		repeat (4) @(posedge CLK);
		btn_raw <= '0;
		repeat (12) @(posedge CLK);
		@(negedge CLK);
	endtask

	task automatic press_button(input int idx);
		btn_vec_t mask;
		mask      = '0;
		mask[idx] = 1'b1;
		press_buttons(mask);
	endtask

	task automatic wait_led_a(input int limit);
		int n;
		n = 0;
		while (led_a !== 1'b1 && n < limit) begin
			@(negedge CLK);
			n++;
		end
		if (led_a !== 1'b1) begin
			$display("Load of operand A did not finish within %0d cycles", limit);
			$display("Simulation failed");
			$fatal(1, "no load acknowledge");
		end
	endtask

	task automatic wait_lamps_off(input int limit);
		int n;
		n = 0;
		while ({led_a, led_b, led_ls, led_ms} !== 4'b0000 && n < limit) begin
			@(negedge CLK);
			n++;
		end
		if ({led_a, led_b, led_ls, led_ms} !== 4'b0000) begin
			$display("Lamps stayed on %0d cycles after the init button", limit);
			$display("Simulation failed");
			$fatal(1, "init not taken");
		end
	endtask

	task automatic load_a_value(input bcd_pair_t v);
		set_switches(v);
		press_button(BTN_LOAD_A);
		cur_a = v;
		check_lamps(1'b1, 1'b0, 1'b0, 1'b0);
		check_bit("bcd_err", 1'b0, bcd_err);
		expect_pair(v);
	endtask

	task automatic load_b_value(input bcd_pair_t v);
		set_switches(v);
		press_button(BTN_LOAD_B);
		cur_b = v;
		check_lamps(1'b0, 1'b1, 1'b0, 1'b0);
		check_bit("bcd_err", 1'b0, bcd_err);
		expect_pair(v);
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	// Init falls through to loading A with the reset switches
	task automatic test_reset_load();
		repeat (12) @(posedge CLK);
		@(negedge CLK);
		cur_a = 8'h47;
		cur_b = 8'h00;
		check_lamps(1'b1, 1'b0, 1'b0, 1'b0);
		check_bit("bcd_err", 1'b0, bcd_err);
		expect_pair(8'h47);
	endtask

	task automatic test_invalid_switches();
		// Tens nibble of 12
		set_switches(8'hC3);
		press_button(BTN_LOAD_A);
		check_bit("bcd_err", 1'b1, bcd_err);
		check_lamps(1'b0, 1'b0, 1'b0, 1'b0);
		check_segs("seg_hi", SEG_BLANK, seg_hi);
		check_segs("seg_lo", SEG_BLANK, seg_lo);
		// Request still pending, goes through once legal
		set_switches(8'h25);
		cur_a = 8'h25;
		wait_led_a(LOAD_WAIT);
		@(negedge CLK);
		check_bit("bcd_err", 1'b0, bcd_err);
		expect_pair(8'h25);
	endtask

	task automatic test_load_b();
		bcd_pair_t keep_a;
		keep_a = cur_a;
		load_b_value(8'h61);
		// Sum of the kept A and the new B shows A survived the B load
		press_button(BTN_DISP_LS);
		check_lamps(1'b0, 1'b0, 1'b1, 1'b0);
		expect_sum_low();
		// Back to A through the load path with the same switches
		load_a_value(keep_a);
	endtask

	task automatic test_random_sums();
		for (int i = 0; i < N_RANDOM; i++) begin
			load_a_value(random_operand());
			load_b_value(random_operand());
			press_button(BTN_DISP_LS);
			check_lamps(1'b0, 1'b0, 1'b1, 1'b0);
			expect_sum_low();
			press_button(BTN_DISP_MS);
			check_lamps(1'b0, 1'b0, 1'b0, 1'b1);
			expect_hundreds();
		end
	endtask

	task automatic test_priority();
		btn_vec_t mask;
		// 99 plus anything nonzero gives a hundreds digit
		load_a_value(8'h99);
		mask              = '0;
		mask[BTN_LOAD_B]  = 1'b1;
		mask[BTN_DISP_MS] = 1'b1;
		press_buttons(mask);
		check_lamps(1'b0, 1'b0, 1'b0, 1'b1);
		expect_hundreds();
		// Display low beats load A
		mask              = '0;
		mask[BTN_LOAD_A]  = 1'b1;
		mask[BTN_DISP_LS] = 1'b1;
		press_buttons(mask);
		check_lamps(1'b0, 1'b0, 1'b1, 1'b0);
		expect_sum_low();
	endtask

	task automatic test_init();
		set_switches(8'h58);
		@(posedge CLK);
		btn_raw[BTN_INIT] <= 1'b1;
		wait_lamps_off(LOAD_WAIT);
		@(posedge CLK);
		btn_raw <= '0;
		cur_a = 8'h58;
		wait_led_a(LOAD_WAIT);
		@(negedge CLK);
		check_bit("bcd_err", 1'b0, bcd_err);
		expect_pair(8'h58);
	endtask

	initial begin
		void'($urandom(32'h58e5_0309));
		rst     <= 1'b1;
		sw      <= 8'h47;
		btn_raw <= '0;
		repeat (8) @(posedge CLK);
		rst <= 1'b0;
		test_reset_load();
		test_invalid_switches();
		test_load_b();
		test_random_sums();
		test_priority();
		test_init();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- sim.f
verilog/bcd_pkg.sv
verilog/button_sync.sv
verilog/bcd_add_controller.sv
verilog/operand_store.sv
verilog/bcd_adder.sv
verilog/display_mux.sv
verilog/bcd_add_top.sv
bench/bcd_add_props.sv
bench/bcd_add_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = bcd_add_tb
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Test run FAILED, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
